//--- flist.f
src/dfu_pkg.sv
src/ctrl_xfr_fsm.sv
src/setup_capture.sv
src/request_handler.sv
src/dfu_state_unit.sv
src/descriptor_reader.sv
src/dfu_ctrl_ep_top.sv
verif/dfu_ctrl_ep_props.sv
verif/dfu_ctrl_ep_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dfu control endpoint testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module dfu_ctrl_ep_tb -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

//--- src/ctrl_xfr_fsm.sv
`default_nettype none

module ctrl_xfr_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                out_ep_grant,
  input  logic                out_ep_data_avail,
  input  logic                out_ep_setup,
  input  logic                out_ep_acked,
  input  logic                in_ep_grant,
  input  logic                in_ep_acked,
  input  logic                in_ep_stall,
  input  logic                rom_empty,
  input  logic                in_ep_data_put,
  input  dfu_pkg::setup_pkt_t setup,
  output logic                out_ep_req,
  output logic                out_ep_data_get,
  output logic                in_ep_req,
  output logic                in_ep_data_done,
  output logic                setup_end,
  output logic                status_end,
  output logic                out_stage_done,
  output logic                in_take,
  output logic                setup_valid
);
  import dfu_pkg::*;

  xfr_state_e state, state_next;
  word_t      data_count;   // bytes left in the data stage
  logic       avail_q;
  logic       pkt_start;
  logic       pkt_end;
  logic       all_sent_q;
  logic       has_data;
  logic       all_data_sent;
  logic       out_take;

  // control endpoint always drains the out buffer
  assign out_ep_req      = out_ep_data_avail;
  assign out_ep_data_get = out_ep_data_avail;

  ////////////////////////////////////////
  // packet edges
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q     <= 1'b0;
      pkt_start   <= 1'b0;
      pkt_end     <= 1'b0;
      setup_valid <= 1'b0;
      all_sent_q  <= 1'b0;
    end else begin
      avail_q     <= out_ep_data_avail;
      pkt_start   <= out_ep_data_avail && !avail_q && out_ep_setup;
      pkt_end     <= !out_ep_data_avail && avail_q;
      setup_valid <= out_ep_grant && out_ep_data_get && out_ep_setup; // data follows grant
      all_sent_q  <= all_data_sent;
    end
  end

  assign has_data      = |setup.length;
  assign all_data_sent = (state == DATA_IN) && (rom_empty || data_count == '0);
  assign in_ep_req     = (state == DATA_IN) && !all_data_sent;
  assign in_take       = in_ep_grant && in_ep_data_put;
  assign out_take      = (state == DATA_OUT) && !out_ep_setup && out_ep_grant && out_ep_data_get;

  assign setup_end      = (state == SETUP_DONE);
  assign out_stage_done = (state == DATA_OUT) && (data_count == '0);
  assign status_end     = ((state == DATA_IN) && in_ep_stall)
                       || ((state == STATUS_IN) && in_ep_acked)
                       || ((state == STATUS_OUT) && out_ep_acked);

  // last in byte gone, or zero-length status packet
  assign in_ep_data_done = (all_data_sent && !all_sent_q && !in_ep_stall)
                        || (setup_end && !has_data)
                        || out_stage_done;

  ////////////////////////////////////////
  // transfer state machine
  ////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      IDLE:       if (pkt_start) state_next = SETUP_IN;
      SETUP_IN:   if (pkt_end) state_next = SETUP_DONE;
      SETUP_DONE: begin
        if (has_data && setup.request_type[7]) state_next = DATA_IN;
        else if (has_data) state_next = DATA_OUT;
        else state_next = STATUS_IN;
      end
      DATA_IN: begin
        if (in_ep_stall) state_next = IDLE;
        else if (in_ep_acked && all_data_sent) state_next = STATUS_OUT;
      end
      DATA_OUT:   if (out_stage_done) state_next = STATUS_IN;
      STATUS_IN:  if (in_ep_acked) state_next = IDLE;
      STATUS_OUT: if (out_ep_acked) state_next = IDLE;
      default:    state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      data_count <= '0;
    end else begin
      state <= state_next;
      if (setup_end) data_count <= setup.length;
      else if (in_take || out_take) data_count <= data_count - 16'd1;
    end
  end

endmodule

`default_nettype wire

//--- src/descriptor_reader.sv
`default_nettype none

module descriptor_reader (
  input  logic               clk,
  input  logic               reset,
  input  logic               setup_end,
  input  logic               status_end,
  input  logic               in_take,
  input  logic               in_ep_req,
  input  logic               in_ep_data_free,
  input  dfu_pkg::rom_load_t rom_load,
  input  dfu_pkg::dfu_regs_t regs,
  output dfu_pkg::byte_t     in_ep_data,
  output logic               in_ep_data_put,
  output logic               rom_empty
);
  import dfu_pkg::*;

  rom_src_e  src;
  rom_addr_t ptr;
  word_t     remain;
  byte_t     dev_byte;
  byte_t     cfg_byte;
  byte_t     stat_byte;

  always_ff @(posedge clk) begin
    if (reset || status_end) begin
      src    <= SRC_DEVICE;
      ptr    <= '0;
      remain <= '0;
    end else if (setup_end) begin
      src    <= rom_load.src;
      ptr    <= rom_load.start;
      remain <= rom_load.length;
    end else if (in_take) begin
      ptr    <= ptr + 9'd1;
      remain <= remain - 16'd1;
    end
  end

  assign rom_empty      = (remain == '0);
  assign in_ep_data_put = in_ep_req && in_ep_data_free;

  ////////////////////////////////////////
  // byte tables, unlisted entries are 0
  ////////////////////////////////////////
  always_comb begin
    case (ptr)
      9'd0:    dev_byte = DEVICE_DESC_LEN[7:0];
      9'd1:    dev_byte = 8'd1;               // device
      9'd3:    dev_byte = 8'h01;              // bcdUSB high
      9'd7:    dev_byte = MAX_PACKET_SIZE;
      9'd8:    dev_byte = VENDOR_ID[7:0];
      9'd9:    dev_byte = VENDOR_ID[15:8];
      9'd10:   dev_byte = PRODUCT_ID[7:0];
      9'd11:   dev_byte = PRODUCT_ID[15:8];
      9'd17:   dev_byte = 8'd1;               // one configuration
      default: dev_byte = 8'h00;
    endcase
  end

  always_comb begin
    case (ptr)
      9'd0:    cfg_byte = 8'd9;
      9'd1:    cfg_byte = 8'd2;               // configuration
      9'd2:    cfg_byte = CONFIG_TOTAL_LEN[7:0];
      9'd3:    cfg_byte = CONFIG_TOTAL_LEN[15:8];
      9'd4:    cfg_byte = 8'd1;               // interfaces
      9'd5:    cfg_byte = 8'd1;               // config value
      9'd7:    cfg_byte = 8'hc0;              // self powered
      9'd8:    cfg_byte = 8'd50;              // 100 mA
      9'd9:    cfg_byte = 8'd9;
      9'd10:   cfg_byte = 8'd4;               // interface
      9'd14:   cfg_byte = 8'hfe;              // application specific
      9'd15:   cfg_byte = 8'd1;               // dfu subclass
      9'd16:   cfg_byte = 8'd2;               // dfu mode protocol
      9'd18:   cfg_byte = 8'd9;
      9'd19:   cfg_byte = 8'h21;              // dfu functional
      9'd20:   cfg_byte = 8'h05;              // download, manifest tolerant
      9'd21:   cfg_byte = DETACH_TIMEOUT[7:0];
      9'd22:   cfg_byte = DETACH_TIMEOUT[15:8];
      9'd23:   cfg_byte = TRANSFER_SIZE[7:0];
      9'd24:   cfg_byte = TRANSFER_SIZE[15:8];
      9'd25:   cfg_byte = 8'h10;              // dfu 1.1
      9'd26:   cfg_byte = 8'h01;
      default: cfg_byte = 8'h00;
    endcase
  end

  // getstatus reply, poll timeout of 1 ms
  always_comb begin
    case (ptr)
      9'd0:    stat_byte = regs.status;
      9'd1:    stat_byte = 8'd1;
      9'd4:    stat_byte = regs.state;
      default: stat_byte = 8'h00;
    endcase
  end

  always_comb begin
    case (src)
      SRC_DEVICE:    in_ep_data = dev_byte;
      SRC_CONFIG:    in_ep_data = cfg_byte;
      SRC_DFUSTATUS: in_ep_data = stat_byte;
      default:       in_ep_data = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

//--- src/dfu_ctrl_ep_top.sv
`default_nettype none

module dfu_ctrl_ep_top (
  input  logic                clk,
  input  logic                reset,
  // out endpoint
  output logic                out_ep_req,
  input  logic                out_ep_grant,
  input  logic                out_ep_data_avail,
  input  logic                out_ep_setup,
  output logic                out_ep_data_get,
  input  dfu_pkg::byte_t      out_ep_data,
  input  logic                out_ep_acked,
  // in endpoint
  output logic                in_ep_req,
  input  logic                in_ep_grant,
  input  logic                in_ep_data_free,
  output logic                in_ep_data_put,
  output dfu_pkg::byte_t      in_ep_data,
  output logic                in_ep_data_done,
  output logic                in_ep_stall,
  input  logic                in_ep_acked,
  // device state
  output dfu_pkg::dev_addr_t  dev_addr,
  output dfu_pkg::dfu_state_t dfu_state
);
  import dfu_pkg::*;

  setup_pkt_t setup;
  rom_load_t  rom_load;
  dfu_cmd_e   dfu_cmd;
  dfu_regs_t  regs;
  logic       setup_valid;
  logic       setup_end;
  logic       status_end;
  logic       out_stage_done;
  logic       in_take;
  logic       rom_empty;

  ctrl_xfr_fsm u_fsm (
    .clk, .reset,
    .out_ep_grant, .out_ep_data_avail, .out_ep_setup, .out_ep_acked,
    .in_ep_grant, .in_ep_acked, .in_ep_stall, .rom_empty, .in_ep_data_put,
    .setup,
    .out_ep_req, .out_ep_data_get, .in_ep_req, .in_ep_data_done,
    .setup_end, .status_end, .out_stage_done, .in_take, .setup_valid
  );

  setup_capture u_setup (
    .clk, .reset, .setup_valid, .status_end, .out_ep_data, .setup
  );

  request_handler u_req (
    .clk, .reset, .setup_end, .status_end, .setup,
    .rom_load, .dfu_cmd, .in_ep_stall, .dev_addr
  );

  dfu_state_unit u_dfu (
    .clk, .reset, .setup_end, .out_stage_done, .dfu_cmd, .setup,
    .regs, .dfu_state
  );

  descriptor_reader u_rom (
    .clk, .reset, .setup_end, .status_end, .in_take, .in_ep_req, .in_ep_data_free,
    .rom_load, .regs,
    .in_ep_data, .in_ep_data_put, .rom_empty
  );

endmodule

`default_nettype wire

//--- src/dfu_pkg.sv
`default_nettype none

package dfu_pkg;

  ////////////////////////////////////////
  // basic widths
  ////////////////////////////////////////
  typedef logic [7:0]  byte_t;        // endpoint data byte
  typedef logic [15:0] word_t;        // setup value / length
  typedef logic [6:0]  dev_addr_t;
  typedef logic [8:0]  rom_addr_t;    // descriptor read pointer
  typedef logic [7:0]  dfu_state_t;   // bState
  typedef logic [7:0]  dfu_status_t;  // bStatus

  typedef enum logic [2:0] {
    IDLE, SETUP_IN, SETUP_DONE, DATA_IN, DATA_OUT, STATUS_IN, STATUS_OUT
  } xfr_state_e;

  typedef enum logic [1:0] {
    SRC_DEVICE, SRC_CONFIG, SRC_DFUSTATUS
  } rom_src_e;

  typedef enum logic [2:0] {
    CMD_NONE, CMD_SET_CONFIG, CMD_DNLOAD, CMD_GETSTATUS, CMD_CLRSTATUS, CMD_ABORT
  } dfu_cmd_e;

  // dfu bState codes
  localparam dfu_state_t appIDLE          = 8'h00;
  localparam dfu_state_t dfuIDLE          = 8'h02;
  localparam dfu_state_t dfuDNLOAD_SYNC   = 8'h03;
  localparam dfu_state_t dfuDNBUSY        = 8'h04;
  localparam dfu_state_t dfuDNLOAD_IDLE   = 8'h05;
  localparam dfu_state_t dfuMANIFEST_SYNC = 8'h06;
  localparam dfu_state_t dfuERROR         = 8'h0a;

  // dfu bStatus codes
  localparam dfu_status_t STATUS_OK   = 8'h00;
  localparam dfu_status_t ERR_WRITE   = 8'h03;
  localparam dfu_status_t ERR_ADDRESS = 8'h08;

  localparam byte_t MAX_PACKET_SIZE  = 8'd32;
  localparam word_t DEVICE_DESC_LEN  = 16'd18;
  localparam word_t CONFIG_TOTAL_LEN = 16'd27;  // config + interface + dfu functional
  localparam word_t PART_BLOCKS      = 16'd16;  // blocks in the single partition
  localparam word_t DETACH_TIMEOUT   = 16'd1000;
  localparam word_t TRANSFER_SIZE    = 16'd256;
  localparam word_t VENDOR_ID        = 16'h1d50;
  localparam word_t PRODUCT_ID       = 16'h6130;

  ////////////////////////////////////////
  // structs passed between blocks
  ////////////////////////////////////////
  typedef struct packed {
    byte_t request_type;
    byte_t request;
    word_t value;
    word_t length;
  } setup_pkt_t;

  typedef struct packed {
    rom_src_e  src;
    rom_addr_t start;
    word_t     length;
  } rom_load_t;

  typedef struct packed {
    dfu_status_t status;
    dfu_state_t  state;
  } dfu_regs_t;

endpackage

`default_nettype wire

//--- src/dfu_state_unit.sv
`default_nettype none

module dfu_state_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                setup_end,
  input  logic                out_stage_done,
  input  dfu_pkg::dfu_cmd_e   dfu_cmd,
  input  dfu_pkg::setup_pkt_t setup,
  output dfu_pkg::dfu_regs_t  regs,
  output dfu_pkg::dfu_state_t dfu_state
);
  import dfu_pkg::*;

  dfu_state_t  state;
  dfu_status_t status;
  word_t       block_end;  // first block past the partition

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= appIDLE;
      status <= STATUS_OK;
    end else begin
      // end of out data stage stands in for the write finishing
      if (out_stage_done && state == dfuDNBUSY) state <= dfuDNLOAD_SYNC;

      if (setup_end) begin
        case (dfu_cmd)
          CMD_SET_CONFIG: state <= (setup.value != '0) ? dfuIDLE : appIDLE;
          CMD_DNLOAD: begin
            if (state == dfuIDLE) begin
              state <= dfuDNBUSY;              // new download
            end else if (state != dfuDNLOAD_IDLE) begin
              status <= ERR_WRITE;             // not ready for a block
              state  <= dfuERROR;
            end else if (setup.length == '0) begin
              status <= STATUS_OK;             // final block
              state  <= dfuMANIFEST_SYNC;
            end else if (setup.value >= block_end) begin
              status <= ERR_ADDRESS;
              state  <= dfuERROR;
            end else begin
              state <= dfuDNBUSY;
            end
          end
          CMD_GETSTATUS: begin
            if (state == dfuDNLOAD_SYNC) state <= dfuDNLOAD_IDLE;
            if (state == dfuMANIFEST_SYNC) state <= dfuIDLE;
          end
          CMD_CLRSTATUS: begin
            status <= STATUS_OK;
            state  <= dfuIDLE;
          end
          CMD_ABORT: state <= dfuIDLE;
          default: ;
        endcase
      end
    end
  end

  // block range fixed by the first dnload
  always_ff @(posedge clk) begin
    if (setup_end && dfu_cmd == CMD_DNLOAD && state == dfuIDLE) begin
      block_end <= setup.value + PART_BLOCKS;
    end
  end

  assign regs.status = status;
  assign regs.state  = state;
  assign dfu_state   = state;

endmodule

`default_nettype wire

//--- src/request_handler.sv
`default_nettype none

module request_handler (
  input  logic                clk,
  input  logic                reset,
  input  logic                setup_end,
  input  logic                status_end,
  input  dfu_pkg::setup_pkt_t setup,
  output dfu_pkg::rom_load_t  rom_load,
  output dfu_pkg::dfu_cmd_e   dfu_cmd,
  output logic                in_ep_stall,
  output dfu_pkg::dev_addr_t  dev_addr
);
  import dfu_pkg::*;

  logic      stall_req;
  logic      addr_req;
  logic      addr_pending;
  dev_addr_t new_addr;

  ////////////////////////////////////////
  // request decode, sampled at setup_end
  ////////////////////////////////////////
  always_comb begin
    rom_load  = '{src: SRC_DEVICE, start: '0, length: '0}; // zero-length by default
    dfu_cmd   = CMD_NONE;
    stall_req = 1'b0;
    addr_req  = 1'b0;

    case ({setup.request_type[6:5], setup.request})
      10'h006: begin // get_descriptor
        case (setup.value[15:8])
          8'd1: rom_load.length = DEVICE_DESC_LEN;
          8'd2: begin
            rom_load.src    = SRC_CONFIG;
            rom_load.length = CONFIG_TOTAL_LEN;
          end
          8'd6: stall_req = 1'b1;  // device_qualifier, full speed only
          default: ;
        endcase
      end
      10'h005: addr_req = 1'b1;           // set_address
      10'h009: dfu_cmd = CMD_SET_CONFIG;
      10'h00b: ;                          // set_interface, one alt setting
      10'h101: dfu_cmd = CMD_DNLOAD;      // block bytes dropped
      10'h103: begin
        dfu_cmd         = CMD_GETSTATUS;
        rom_load.src    = SRC_DFUSTATUS;
        rom_load.length = 16'd6;
      end
      10'h104: dfu_cmd = CMD_CLRSTATUS;
      10'h105: begin // getstate, just the bState byte
        rom_load.src    = SRC_DFUSTATUS;
        rom_load.start  = 9'd4;
        rom_load.length = 16'd1;
      end
      10'h106: dfu_cmd = CMD_ABORT;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // stall pulse and device address
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      in_ep_stall  <= 1'b0;
      addr_pending <= 1'b0;
      dev_addr     <= '0;
    end else begin
      in_ep_stall <= setup_end && stall_req;
      if (setup_end && addr_req) begin
        addr_pending <= 1'b1;
      end else if (status_end) begin
        addr_pending <= 1'b0;
      end
      // status token still goes to the old address
      if (status_end && addr_pending) dev_addr <= new_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_end && addr_req) new_addr <= setup.value[6:0];
  end

endmodule

`default_nettype wire

//--- src/setup_capture.sv
`default_nettype none

module setup_capture (
  input  logic                clk,
  input  logic                reset,
  input  logic                setup_valid,
  input  logic                status_end,
  input  dfu_pkg::byte_t      out_ep_data,
  output dfu_pkg::setup_pkt_t setup
);
  import dfu_pkg::*;

  byte_t      store [8];   // raw setup bytes
  logic [2:0] index;

  always_ff @(posedge clk) begin
    if (reset || status_end) begin
      index <= '0;
    end else if (setup_valid) begin
      index <= index + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_valid) store[index] <= out_ep_data;
  end

  // usb fields are little-endian, windex bytes 4 and 5 unused
  assign setup.request_type = store[0];
  assign setup.request      = store[1];
  assign setup.value        = {store[3], store[2]};
  assign setup.length       = {store[7], store[6]};

endmodule

`default_nettype wire

//--- verif/dfu_ctrl_ep_props.sv
`default_nettype none

module dfu_ctrl_ep_props (
  input logic                clk,
  input logic                reset,
  input dfu_pkg::xfr_state_e state,
  input logic                in_ep_req,
  input logic                in_ep_data_put,
  input logic                in_ep_data_done
);
  import dfu_pkg::*;

  // a byte is offered only while bytes are requested
  put_needs_req: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_put |-> in_ep_req)
    else $error("in_ep_data_put high without in_ep_req");

  done_one_cycle: assert property (@(posedge clk) disable iff (reset)
    in_ep_data_done |=> !in_ep_data_done)
    else $error("in_ep_data_done held for more than one cycle");

  req_only_in_data: assert property (@(posedge clk) disable iff (reset)
    (state != DATA_IN) |-> !in_ep_req)
    else $error("in_ep_req high outside DATA_IN");

  idle_after_reset: assert property (@(posedge clk)
    reset |=> (state == IDLE))
    else $error("transfer FSM not IDLE after reset");

endmodule

bind ctrl_xfr_fsm dfu_ctrl_ep_props u_props (
  .clk, .reset, .state, .in_ep_req, .in_ep_data_put, .in_ep_data_done
);

`default_nettype wire

//--- verif/dfu_ctrl_ep_tb.sv
`default_nettype none

module dfu_ctrl_ep_tb;
  import dfu_pkg::*;

  localparam int    REC_LEN     = 20;   // bytes per transaction line
  localparam int    MAX_LINES   = 32;
  localparam int    LINE_CYCLES = 400;  // cycle budget per line
  localparam string INPUT_FILE  = "verif/dfu_input.txt";

  logic       clk;
  logic       reset;
  logic       out_ep_req;
  logic       out_ep_grant;
  logic       out_ep_data_avail;
  logic       out_ep_setup;
  logic       out_ep_data_get;
  byte_t      out_ep_data;
  logic       out_ep_acked;
  logic       in_ep_req;
  logic       in_ep_grant;
  logic       in_ep_data_free;
  logic       in_ep_data_put;
  byte_t      in_ep_data;
  logic       in_ep_data_done;
  logic       in_ep_stall;
  logic       in_ep_acked;
  dev_addr_t  dev_addr;
  dfu_state_t dfu_state;

  byte_t       vec_mem [REC_LEN*MAX_LINES];
  byte_t       in_bytes [$];    // bytes taken by the host
  logic [31:0] lfsr;
  dev_addr_t   prev_addr;
  int          error_count;
  int          num_lines;
  int          cycle_count = 0;
  int          cycle_limit = LINE_CYCLES * MAX_LINES;

  dfu_ctrl_ep_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles, a transaction never finished", cycle_count);
      $display("** FAIL **");
      $finish;
    end
  end

  // host side of the in endpoint sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && in_ep_grant && in_ep_data_put) in_bytes.push_back(in_ep_data);
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    return n;
  endfunction

  task automatic random_bit(output logic b);
    lfsr = lfsr_next(lfsr);
    b    = lfsr[0];
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // out endpoint strobes follow avail
  task automatic sample_out_strobes(input logic avail);
    @(negedge clk);
    check_value("out_ep_req", 32'(out_ep_req), 32'(avail));
    check_value("out_ep_data_get", 32'(out_ep_data_get), 32'(avail));
  endtask

  task automatic send_setup(input int base);
    int i;
    for (i = 0; i < 8; i++) begin
      out_ep_setup      = 1'b1;
      out_ep_data_avail = 1'b1;
      out_ep_grant      = 1'b1;
      if (i > 0) out_ep_data = vec_mem[base + i - 1];  // byte follows its grant
      sample_out_strobes(1'b1);
      @(posedge clk);
      #1;
    end
    out_ep_data_avail = 1'b0;
    out_ep_grant      = 1'b0;
    out_ep_data       = vec_mem[base + 7];
    sample_out_strobes(1'b0);
    @(posedge clk);
    #1;
    out_ep_setup = 1'b0;
  endtask

  task automatic send_out_data(input int len);
    int i;
    repeat (4) @(posedge clk);  // data stage opens 2 cycles after setup_end
    #1;
    for (i = 0; i < len; i++) begin
      out_ep_data_avail = 1'b1;
      out_ep_grant      = 1'b1;
      out_ep_data       = byte_t'(i);  // block contents are dropped anyway
      sample_out_strobes(1'b1);
      @(posedge clk);
      #1;
    end
    out_ep_data_avail = 1'b0;
    out_ep_grant      = 1'b0;
  endtask

  // random grant and free gaps until done or stall
  task automatic wait_done(output logic stalled, output logic req_seen);
    logic seen;
    logic b;
    seen     = 1'b0;
    stalled  = 1'b0;
    req_seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      if (in_ep_req) req_seen = 1'b1;
      if (in_ep_stall) begin
        stalled = 1'b1;
        seen    = 1'b1;
      end else if (in_ep_data_done) begin
        seen = 1'b1;
      end
      if (seen) check_value("in_ep_req at done", 32'(in_ep_req), 32'd0);
      @(posedge clk);
      #1;
      if (!seen) begin
        random_bit(b);
        in_ep_grant = b;
        random_bit(b);
        in_ep_data_free = b;
      end
    end
    in_ep_grant     = 1'b0;
    in_ep_data_free = 1'b0;
  endtask

  task automatic ack_status(input logic in_data);
    in_ep_acked = 1'b1;
    @(posedge clk);
    #1;
    in_ep_acked = 1'b0;
    if (in_data) begin  // status stage is an out packet after in data
      out_ep_acked = 1'b1;
      @(posedge clk);
      #1;
      out_ep_acked = 1'b0;
    end
  endtask

  task automatic run_line(input int idx);
    int          base;
    int          n;
    int          k;
    logic        stalled;
    logic        req_seen;
    logic        in_data;
    logic        exp_stall;
    logic [15:0] length;
    base    = idx * REC_LEN;
    length  = {vec_mem[base + 7], vec_mem[base + 6]};
    in_data = vec_mem[base][7] && (length != 16'd0);
    // device_qualifier is refused by a full speed device
    exp_stall = (vec_mem[base] == 8'h80) && (vec_mem[base + 1] == 8'h06)
             && (vec_mem[base + 3] == 8'h06);
    in_bytes.delete();
    send_setup(base);
    if (vec_mem[base + 8] != 8'h00) send_out_data(int'(vec_mem[base + 8]));
    wait_done(stalled, req_seen);
    check_value("in_ep_stall", 32'(stalled), 32'(exp_stall));
    check_value("in_ep_req raised", 32'(req_seen), 32'(vec_mem[base + 9] != 8'h00));
    check_value("dev_addr before status", 32'(dev_addr), 32'(prev_addr));
    if (!stalled) ack_status(in_data);
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("in byte count", 32'(in_bytes.size()), 32'(vec_mem[base + 9]));
    n = in_bytes.size();
    if (n > int'(vec_mem[base + 9])) n = int'(vec_mem[base + 9]);
    if (n > 8) n = 8;
    for (k = 0; k < n; k++) begin
      check_value("in_ep_data", 32'(in_bytes[k]), 32'(vec_mem[base + 10 + k]));
    end
    check_value("dfu_state", 32'(dfu_state), 32'(vec_mem[base + 18]));
    check_value("dev_addr", 32'(dev_addr), 32'(vec_mem[base + 19]));
    prev_addr = vec_mem[base + 19][6:0];
    @(posedge clk);
    #1;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    int    fd;
    int    got;
    int    idx;
    string text;
    reset             = 1'b1;
    out_ep_grant      = 1'b0;
    out_ep_data_avail = 1'b0;
    out_ep_setup      = 1'b0;
    out_ep_data       = '0;
    out_ep_acked      = 1'b0;
    in_ep_grant       = 1'b0;
    in_ep_data_free   = 1'b0;
    in_ep_acked       = 1'b0;
    lfsr              = 32'd70285;
    prev_addr         = '0;
    error_count       = 0;
    num_lines         = 0;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("cannot open %s, there is no stimulus to run", INPUT_FILE);
      $display("** FAIL **");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        got = $fgets(text, fd);
        if (got > 1 && text[0] != "/" && num_lines < MAX_LINES) num_lines++;
      end
      $fclose(fd);
      $readmemh(INPUT_FILE, vec_mem);
      cycle_limit = LINE_CYCLES * num_lines + 20;  // plus reset
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      for (idx = 0; idx < num_lines; idx++) run_line(idx);
      $display("%0d transactions, %0d errors", num_lines, error_count);
      if (error_count == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- verif/dfu_input.txt
// setup bytes (8) | out len | in count | expected in bytes (8) | dfu_state | dev_addr
// all hex, one transaction per line
80 06 00 01 00 00 40 00  00 12  12 01 00 01 00 00 00 20  00 00  // device desc, len 64
80 06 00 01 00 00 08 00  00 08  12 01 00 01 00 00 00 20  00 00  // device desc, len 8
80 06 00 02 00 00 ff 00  00 1b  09 02 1b 00 01 01 00 c0  00 00  // config desc
00 05 2a 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  00 2a  // set_address
80 06 00 06 00 00 0a 00  00 00  00 00 00 00 00 00 00 00  00 2a  // device_qualifier
80 06 00 01 00 00 12 00  00 12  12 01 00 01 00 00 00 20  00 2a
00 09 01 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  02 2a  // set_configuration 1
21 01 00 00 00 00 10 00  10 00  00 00 00 00 00 00 00 00  03 2a  // dnload block 0
a1 03 00 00 00 00 06 00  00 06  00 01 00 00 05 00 00 00  05 2a  // getstatus
21 01 01 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  06 2a  // dnload, zero length
a1 03 00 00 00 00 06 00  00 06  00 01 00 00 02 00 00 00  02 2a
21 01 00 00 00 00 10 00  10 00  00 00 00 00 00 00 00 00  03 2a
a1 03 00 00 00 00 06 00  00 06  00 01 00 00 05 00 00 00  05 2a
21 01 10 00 00 00 10 00  10 00  00 00 00 00 00 00 00 00  0a 2a  // block past the end
a1 05 00 00 00 00 01 00  00 01  0a 00 00 00 00 00 00 00  0a 2a  // getstate
a1 03 00 00 00 00 06 00  00 06  08 01 00 00 0a 00 00 00  0a 2a
21 04 00 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  02 2a  // clrstatus
21 01 00 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  04 2a
21 06 00 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  02 2a  // abort
01 0b 00 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  02 2a  // set_interface
00 09 00 00 00 00 00 00  00 00  00 00 00 00 00 00 00 00  00 2a  // set_configuration 0
